/* common/ring_macros.svh */
`ifndef RING_MACROS_SVH
`define RING_MACROS_SVH

// Number of nodes on the ring
// Node ids run from 1 to RING_NODES and id 0 marks an empty slot
`define RING_NODES 4

// Words held by the memory of each node
`define RING_MEM_WORDS 64

// Destination id carried by broadcast writes
`define RING_BCAST_ID 63

// Top address byte of the node region
// Bits 23 to 20 select the node and bits 7 to 2 select the word
`define RING_REGION_NODE 8'hC0

// Top address byte of the broadcast write region
`define RING_REGION_BCAST 8'hDF

`endif

/* common/ring_pkg.sv */
package ring_pkg;

	// ========================================
	// Ring packets
	// ========================================

	// Kind of packet carried in a ring slot
	// Requests are PT_READ and PT_WRITE, read data returns as PT_ACK
	typedef enum logic [2:0] {
		PT_NONE  = 3'd0,
		PT_READ  = 3'd1,
		PT_WRITE = 3'd2,
		PT_ACK   = 3'd3
	} pkt_type_e;

	// One slot of the request ring or the response ring
	// A slot with sid and did both zero is empty
	typedef struct packed {
		logic [5:0]  sid;
		logic [5:0]  did;
		pkt_type_e   typ;
		logic [3:0]  sel;
		logic [31:0] adr;
		logic [31:0] dat;
	} packet_t;

	// One slot of the interrupt ring
	// An all-zero slot is empty
	typedef struct packed {
		logic [5:0] sid;
		logic [5:0] did;
		logic [7:0] cause;
	} ipacket_t;

	// ========================================
	// Bus ports
	// ========================================

	// CPU side request, cyc and stb are levels held until ack
	typedef struct packed {
		logic        cyc;
		logic        stb;
		logic        we;
		logic [3:0]  sel;
		logic [31:0] adr;
		logic [31:0] dat;
	} bus_req_t;

	// CPU side response, ack is a single cycle pulse
	typedef struct packed {
		logic        ack;
		logic [31:0] dat;
	} bus_rsp_t;

	// Request from the network interface to its local memory
	// The word index is address bits 7 to 2
	typedef struct packed {
		logic        stb;
		logic        we;
		logic [3:0]  sel;
		logic [5:0]  idx;
		logic [31:0] dat;
	} mem_req_t;

	// Local memory response
	typedef struct packed {
		logic        ack;
		logic [31:0] dat;
	} mem_rsp_t;

endpackage

/* src/node_mem.sv */
`include "ring_macros.svh"

module node_mem (
	input  logic               clk_i,
	input  logic               rst_i,
	input  ring_pkg::mem_req_t mem_req_i,
	output ring_pkg::mem_rsp_t mem_rsp_o
);

	// Word storage of one node
	logic [31:0] mem [`RING_MEM_WORDS];

	// A new access is a strobe that has not been acked yet
	// The NIC keeps stb high through the ack cycle, so this stops a second ack
	logic access;

	assign access = mem_req_i.stb && !mem_rsp_o.ack;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			mem_rsp_o.ack <= 1'b0;
			// Memories start out cleared so every word reads back as zero
			for (int w = 0; w < `RING_MEM_WORDS; w++) begin
				mem[w] <= '0;
			end
		end else begin
			// Ack follows the strobe by exactly one cycle
			mem_rsp_o.ack <= access;
			if (access) begin
				// Read data is the word before any write of this cycle
				mem_rsp_o.dat <= mem[mem_req_i.idx];
				if (mem_req_i.we) begin
					// Only the selected byte lanes are written
					for (int b = 0; b < 4; b++) begin
						if (mem_req_i.sel[b]) begin
							mem[mem_req_i.idx][8*b +: 8] <= mem_req_i.dat[8*b +: 8];
						end
					end
				end
			end
		end
	end

endmodule

/* nic/ring_nic.sv */
`include "ring_macros.svh"

module ring_nic #(
	parameter logic [5:0] NODE_ID = 6'd1
) (
	input  logic               clk_i,
	input  logic               rst_i,
	input  ring_pkg::bus_req_t cpu_req_i,
	output ring_pkg::bus_rsp_t cpu_rsp_o,
	output ring_pkg::mem_req_t mem_req_o,
	input  ring_pkg::mem_rsp_t mem_rsp_i,
	input  ring_pkg::packet_t  req_pkt_i,
	output ring_pkg::packet_t  req_pkt_o,
	input  ring_pkg::packet_t  rsp_pkt_i,
	output ring_pkg::packet_t  rsp_pkt_o,
	input  ring_pkg::ipacket_t int_pkt_i,
	output ring_pkg::ipacket_t int_pkt_o,
	input  logic               irq_i,
	input  logic [7:0]         cause_i,
	input  logic [5:0]         server_i,
	output logic               irq_o,
	output logic [7:0]         cause_o
);

	// Memory port states
	typedef enum logic {
		MS_IDLE,
		MS_ACCESS
	} mstate_e;

	// An empty ring slot has no source and no destination
	function automatic logic pkt_empty(input ring_pkg::packet_t p);
		return (p.sid | p.did) == 6'd0;
	endfunction

	// Only ids 1 to RING_NODES have a node behind them
	function automatic logic node_valid(input logic [5:0] id);
		return (id != 6'd0) && (id <= 6'(`RING_NODES));
	endfunction

	// ========================================
	// CPU address decode
	// ========================================

	logic       cpu_strobe;
	logic [7:0] cpu_region;
	logic [5:0] cpu_node;
	logic       cpu_to_node;
	logic       cpu_to_bcast;
	logic       cpu_ring;
	logic [5:0] cpu_did;

	assign cpu_strobe = cpu_req_i.cyc && cpu_req_i.stb;
	assign cpu_region = cpu_req_i.adr[31:24];
	assign cpu_node   = {2'b00, cpu_req_i.adr[23:20]};

	// Node region accesses to a node that does not exist terminate at once
	// Otherwise the packet would circle the ring with no one to take it
	assign cpu_to_node  = (cpu_region == `RING_REGION_NODE) && node_valid(cpu_node);
	// Only writes go out as broadcasts, broadcast reads terminate at once
	assign cpu_to_bcast = (cpu_region == `RING_REGION_BCAST) && cpu_req_i.we;
	assign cpu_ring     = cpu_to_node || cpu_to_bcast;
	assign cpu_did      = cpu_to_bcast ? 6'(`RING_BCAST_ID) : cpu_node;

	// ========================================
	// Ring input classification
	// ========================================

	mstate_e           mstate;
	ring_pkg::packet_t tx_buf;
	ring_pkg::packet_t rsp_buf;
	ring_pkg::packet_t bc_buf;
	logic              bc_valid;
	ring_pkg::packet_t cur_pkt;
	logic              cpu_busy;
	logic              rd_wait;
	logic [31:0]       rd_adr;
	logic              irq_pend;
	ring_pkg::ipacket_t irq_pkt;

	logic              mem_idle;
	logic              req_for_me;
	logic              req_bcast;
	logic              req_own_bc;
	logic              uni_ok;
	logic              bc_direct;
	logic              bc_latch;
	logic              mem_start;
	ring_pkg::packet_t mem_src;
	logic              rsp_for_me;
	logic              rd_match;
	logic              int_hit;
	logic              int_empty;

	assign mem_idle   = (mstate == MS_IDLE);
	assign req_for_me = (req_pkt_i.did == NODE_ID);
	assign req_bcast  = (req_pkt_i.did == 6'(`RING_BCAST_ID)) &&
		(req_pkt_i.typ == ring_pkg::PT_WRITE);
	assign req_own_bc = req_bcast && (req_pkt_i.sid == NODE_ID);

	// A unicast request is taken when the memory port is free
	// A read also needs an empty response buffer, otherwise it keeps circling
	assign uni_ok = req_for_me && mem_idle && !bc_valid &&
		((req_pkt_i.typ == ring_pkg::PT_WRITE) ||
		((req_pkt_i.typ == ring_pkg::PT_READ) && pkt_empty(rsp_buf)));

	// Broadcasts go straight to memory when nothing else is waiting
	assign bc_direct = req_bcast && mem_idle && !bc_valid;
	// Otherwise they park in bc_buf if it is free or drains this cycle
	assign bc_latch  = req_bcast && !bc_direct && (mem_idle || !bc_valid);

	// The parked broadcast goes before anything new from the ring
	assign mem_src   = bc_valid ? bc_buf : req_pkt_i;
	assign mem_start = mem_idle && (bc_valid || uni_ok || bc_direct);

	// Read data returning for this node, matched against the waiting read
	assign rsp_for_me = (rsp_pkt_i.did == NODE_ID) && (rsp_pkt_i.typ == ring_pkg::PT_ACK);
	assign rd_match   = rsp_for_me && rd_wait && (rsp_pkt_i.adr == rd_adr);

	assign int_hit   = (int_pkt_i.did == NODE_ID);
	assign int_empty = (int_pkt_i == '0);

	// ========================================
	// Request ring and CPU port
	// ========================================

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			req_pkt_o     <= '0;
			tx_buf        <= '0;
			cpu_rsp_o.ack <= 1'b0;
			cpu_busy      <= 1'b0;
			rd_wait       <= 1'b0;
		end else begin
			cpu_rsp_o.ack <= 1'b0;

			// Every slot moves one hop per cycle
			req_pkt_o <= req_pkt_i;

			// Remove what this node consumes, own broadcasts only once done here
			if (uni_ok || (req_own_bc && (bc_direct || bc_latch))) begin
				req_pkt_o <= '0;
			end else if (pkt_empty(req_pkt_i) && !pkt_empty(tx_buf)) begin
				// Pending request goes into the free slot
				req_pkt_o <= tx_buf;
				tx_buf    <= '0;
			end

			// The CPU has to drop stb before a new cycle is accepted
			if (!cpu_strobe) begin
				cpu_busy <= 1'b0;
			end else if (!cpu_busy) begin
				if (!cpu_ring) begin
					// Unmapped address or broadcast read ends with zero data
					cpu_rsp_o.ack <= 1'b1;
					cpu_rsp_o.dat <= '0;
					cpu_busy      <= 1'b1;
				end else if (pkt_empty(tx_buf)) begin
					// A full transmit buffer holds the strobe off
					tx_buf <= '{
						sid: NODE_ID,
						did: cpu_did,
						typ: cpu_req_i.we ? ring_pkg::PT_WRITE : ring_pkg::PT_READ,
						sel: cpu_req_i.sel,
						adr: cpu_req_i.adr,
						dat: cpu_req_i.dat
					};
					cpu_busy <= 1'b1;
					if (cpu_req_i.we) begin
						// Writes are posted
						cpu_rsp_o.ack <= 1'b1;
						cpu_rsp_o.dat <= '0;
					end else begin
						rd_wait <= 1'b1;
						rd_adr  <= cpu_req_i.adr;
					end
				end
			end

			// Read ends when its response comes round
			if (rd_match) begin
				cpu_rsp_o.ack <= 1'b1;
				cpu_rsp_o.dat <= rsp_pkt_i.dat;
				rd_wait       <= 1'b0;
			end
		end
	end

	// ========================================
	// Memory port and response ring
	// ========================================

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			mstate        <= MS_IDLE;
			mem_req_o.stb <= 1'b0;
			bc_valid      <= 1'b0;
			rsp_pkt_o     <= '0;
			rsp_buf       <= '0;
		end else begin
			rsp_pkt_o <= rsp_pkt_i;

			// Responses to this node always leave the ring, matched or not
			if (rsp_for_me) begin
				rsp_pkt_o <= '0;
			end else if (pkt_empty(rsp_pkt_i) && !pkt_empty(rsp_buf)) begin
				rsp_pkt_o <= rsp_buf;
				rsp_buf   <= '0;
			end

			// Parked broadcast drains when the port starts on it
			if (mem_idle && bc_valid) begin
				bc_valid <= 1'b0;
			end
			if (bc_latch) begin
				bc_buf   <= req_pkt_i;
				bc_valid <= 1'b1;
			end

			case (mstate)
				MS_IDLE: begin
					if (mem_start) begin
						cur_pkt       <= mem_src;
						mem_req_o.stb <= 1'b1;
						mem_req_o.we  <= (mem_src.typ == ring_pkg::PT_WRITE);
						mem_req_o.sel <= mem_src.sel;
						mem_req_o.idx <= mem_src.adr[7:2];
						mem_req_o.dat <= mem_src.dat;
						mstate        <= MS_ACCESS;
					end
				end
				MS_ACCESS: begin
					// Strobe falls the cycle after ack, idle lasts at least one cycle
					if (mem_rsp_i.ack) begin
						mem_req_o.stb <= 1'b0;
						mstate        <= MS_IDLE;
						if (cur_pkt.typ == ring_pkg::PT_READ) begin
							rsp_buf <= '{
								sid: NODE_ID,
								did: cur_pkt.sid,
								typ: ring_pkg::PT_ACK,
								sel: cur_pkt.sel,
								adr: cur_pkt.adr,
								dat: mem_rsp_i.dat
							};
						end
					end
				end
				default: mstate <= MS_IDLE;
			endcase
		end
	end

	// ========================================
	// Interrupt ring
	// ========================================

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			int_pkt_o <= '0;
			irq_o     <= 1'b0;
			irq_pend  <= 1'b0;
		end else begin
			irq_o     <= 1'b0;
			int_pkt_o <= int_pkt_i;

			if (int_hit) begin
				// Delivered here, slot is freed
				int_pkt_o <= '0;
				irq_o     <= 1'b1;
				cause_o   <= int_pkt_i.cause;
			end else if (int_empty && irq_pend) begin
				int_pkt_o <= irq_pkt;
				irq_pend  <= 1'b0;
			end

			// A raise aimed at a missing node is dropped, it would never be taken
			if (irq_i && node_valid(server_i)) begin
				irq_pend <= 1'b1;
				irq_pkt  <= '{sid: NODE_ID, did: server_i, cause: cause_i};
			end
		end
	end

endmodule

/* src/ring_top.sv */
`include "ring_macros.svh"

module ring_top (
	input  logic                                    clk_i,
	input  logic                                    rst_i,
	input  ring_pkg::bus_req_t [`RING_NODES-1:0]    cpu_req_i,
	output ring_pkg::bus_rsp_t [`RING_NODES-1:0]    cpu_rsp_o,
	input  logic [`RING_NODES-1:0]                  irq_i,
	input  logic [`RING_NODES-1:0][7:0]             cause_i,
	input  logic [`RING_NODES-1:0][5:0]             server_i,
	output logic [`RING_NODES-1:0]                  irq_o,
	output logic [`RING_NODES-1:0][7:0]             cause_o
);

	// ========================================
	// Ring links
	// ========================================

	// Entry i is the output register of the node with id i+1
	// The next node takes it as its input, the last one wraps to the first
	ring_pkg::packet_t  req_ring [`RING_NODES];
	ring_pkg::packet_t  rsp_ring [`RING_NODES];
	ring_pkg::ipacket_t int_ring [`RING_NODES];

	// Local memory port of each node
	ring_pkg::mem_req_t mem_req [`RING_NODES];
	ring_pkg::mem_rsp_t mem_rsp [`RING_NODES];

	// ========================================
	// Nodes
	// ========================================

	for (genvar i = 0; i < `RING_NODES; i++) begin : g_node
		// Upstream neighbour on all three rings
		localparam int PREV = (i + `RING_NODES - 1) % `RING_NODES;

		ring_nic #(
			.NODE_ID(6'(i + 1))
		) ring_nic_inst (
			.clk_i     (clk_i),
			.rst_i     (rst_i),
			.cpu_req_i (cpu_req_i[i]),
			.cpu_rsp_o (cpu_rsp_o[i]),
			.mem_req_o (mem_req[i]),
			.mem_rsp_i (mem_rsp[i]),
			.req_pkt_i (req_ring[PREV]),
			.req_pkt_o (req_ring[i]),
			.rsp_pkt_i (rsp_ring[PREV]),
			.rsp_pkt_o (rsp_ring[i]),
			.int_pkt_i (int_ring[PREV]),
			.int_pkt_o (int_ring[i]),
			.irq_i     (irq_i[i]),
			.cause_i   (cause_i[i]),
			.server_i  (server_i[i]),
			.irq_o     (irq_o[i]),
			.cause_o   (cause_o[i])
		);

		// Each node owns one memory, reached only through its NIC
		node_mem node_mem_inst (
			.clk_i     (clk_i),
			.rst_i     (rst_i),
			.mem_req_i (mem_req[i]),
			.mem_rsp_o (mem_rsp[i])
		);
	end

endmodule

/* sim/ring_tb.sv */
`include "ring_macros.svh"

module ring_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int NODES  = `RING_NODES;
	localparam int WORDS  = `RING_MEM_WORDS;
	localparam int N_UNI  = 24;
	localparam int N_BC   = 2;
	localparam int N_CONC = 8;
	// Bus operations issued over the whole run set the watchdog budget
	localparam int TOTAL_OPS = NODES*WORDS + 2*N_UNI + N_BC*(1+NODES) + 7 +
		NODES*2*N_CONC + NODES*NODES*N_CONC;
	localparam int WATCHDOG_CYCLES = TOTAL_OPS*400 + 1000;

	logic clk = 1'b0;
	logic rst;
	ring_pkg::bus_req_t [NODES-1:0] cpu_req;
	ring_pkg::bus_rsp_t [NODES-1:0] cpu_rsp;
	logic [NODES-1:0]               irq_in;
	logic [NODES-1:0][7:0]          cause_in;
	logic [NODES-1:0][5:0]          server_in;
	logic [NODES-1:0]               irq_out;
	logic [NODES-1:0][7:0]          cause_out;

	// Expected contents of every node memory indexed by node id minus one
	logic [31:0] model [NODES][WORDS];
	// Each entry of the interrupts still owed holds the node index and the cause
	logic [15:0] exp_irq [$];
	int errors = 0;
	int tests_passed = 0;
	int tests_failed = 0;
	int test_start;
	logic in_reset;

	ring_top ring_top_inst (
		.clk_i    (clk),
		.rst_i    (rst),
		.cpu_req_i(cpu_req),
		.cpu_rsp_o(cpu_rsp),
		.irq_i    (irq_in),
		.cause_i  (cause_in),
		.server_i (server_in),
		.irq_o    (irq_out),
		.cause_o  (cause_out)
	);

	always #4 clk = ~clk;

	// ========================================
	// Address and data helpers
	// ========================================

	// Node region address of word w on the node with index t
	function automatic logic [31:0] node_adr(input int t, input int w);
		return {`RING_REGION_NODE, 4'(t + 1), 12'h000, 6'(w), 2'b00};
	endfunction

	function automatic logic [31:0] bcast_adr(input int w);
		return {`RING_REGION_BCAST, 16'h0000, 6'(w), 2'b00};
	endfunction

	// Only the selected byte lanes take the new data
	function automatic logic [31:0] merge(input logic [31:0] old, input logic [31:0] nw,
		input logic [3:0] sel);
		logic [31:0] res;
		res = old;
		for (int b = 0; b < 4; b++) begin
			if (sel[b]) res[8*b +: 8] = nw[8*b +: 8];
		end
		return res;
	endfunction

	// Mostly full words and about a third with a partial mask
	function automatic logic [3:0] rand_sel();
		return ($urandom_range(0, 2) == 0) ? 4'($urandom_range(1, 14)) : 4'hF;
	endfunction

	// True when no request slot on the ring holds a packet
	function automatic logic ring_idle();
		for (int i = 0; i < NODES; i++) begin
			if (ring_top_inst.req_ring[i].sid != 0 || ring_top_inst.req_ring[i].did != 0)
				return 1'b0;
		end
		return 1'b1;
	endfunction

	// ========================================
	// Bus tasks
	// ========================================

	// One CPU cycle on node n held until ack
	task automatic bus_op(input int n, input logic we, input logic [3:0] sel,
		input logic [31:0] adr, input logic [31:0] wdat, output logic [31:0] rdat);
		ring_pkg::bus_req_t req;
		ring_pkg::bus_rsp_t rsp;
		req = '{cyc: 1'b1, stb: 1'b1, we: we, sel: sel, adr: adr, dat: wdat};
		@(posedge clk);
		#1;
		cpu_req[n] = req;
		do begin
			@(posedge clk);
			#1;
			rsp = cpu_rsp[n];
		end while (!rsp.ack);
		rdat = rsp.dat;
		cpu_req[n] = '0;
	endtask

	task automatic read_check(input int n, input logic [31:0] adr, input logic [31:0] exp);
		logic [31:0] rdat;
		bus_op(n, 1'b0, 4'hF, adr, 32'h0, rdat);
		assert (rdat === exp) else begin
			$display("MISMATCH at %0t: node %0d read %h got %h expected %h",
				$time, n + 1, adr, rdat, exp);
			errors++;
		end
	endtask

	// Posted writes may still be travelling so this waits until the ring stays empty
	task automatic drain_ring();
		int quiet;
		quiet = 0;
		while (quiet < 2*NODES) begin
			@(negedge clk);
			quiet = ring_idle() ? quiet + 1 : 0;
		end
	endtask

	task automatic end_test(input string name);
		if (errors == test_start) begin
			tests_passed++;
			$display("PASS %s", name);
		end else begin
			tests_failed++;
			$display("FAIL %s with %0d errors", name, errors - test_start);
		end
		test_start = errors;
	endtask

	// Writes only words 4*j+n so no other node touches them and reads only settled words
	task automatic node_traffic(input int n);
		int t;
		int w;
		logic [3:0] sel;
		logic [31:0] dat;
		logic [31:0] rdat;
		for (int j = 0; j < N_CONC; j++) begin
			t = $urandom_range(0, NODES - 1);
			w = 4*j + n;
			sel = rand_sel();
			dat = $urandom;
			model[t][w] = merge(model[t][w], dat, sel);
			bus_op(n, 1'b1, sel, node_adr(t, w), dat, rdat);
			t = $urandom_range(0, NODES - 1);
			w = $urandom_range(32, WORDS - 1);
			read_check(n, node_adr(t, w), model[t][w]);
		end
	endtask

	task automatic raise_irq(input int a, input int b, input logic [7:0] cause);
		exp_irq.push_back({8'(b), cause});
		@(posedge clk);
		#1;
		irq_in[a] = 1'b1;
		cause_in[a] = cause;
		server_in[a] = 6'(b + 1);
		@(posedge clk);
		#1;
		irq_in[a] = 1'b0;
	endtask

	task automatic wait_irq_done();
		while (exp_irq.size() != 0) @(posedge clk);
		// Quiet window so a stray pulse still shows up in the monitor
		repeat (4*NODES) @(posedge clk);
	endtask

	// ========================================
	// Monitor
	// ========================================

	always @(negedge clk) begin : monitor
		logic hit;
		ring_pkg::bus_rsp_t rsp;
		for (int i = 0; i < NODES; i++) begin
			rsp = cpu_rsp[i];
			if (in_reset) begin
				assert (rsp.ack === 1'b0 && irq_out[i] === 1'b0) else begin
					$display("MISMATCH at %0t: node %0d raised ack or irq_o in reset",
						$time, i + 1);
					errors++;
				end
			end
			if (irq_out[i] === 1'b1) begin
				hit = 1'b0;
				for (int k = 0; k < exp_irq.size(); k++) begin
					if (!hit && exp_irq[k] == {8'(i), cause_out[i]}) begin
						exp_irq.delete(k);
						hit = 1'b1;
					end
				end
				assert (hit) else begin
					$display("MISMATCH at %0t: unexpected irq_o at node %0d with cause %h",
						$time, i + 1, cause_out[i]);
					errors++;
				end
			end
		end
	end

	// Ends a run that stops making progress
	initial begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("SOME TESTS FAILED");
		$finish;
	end

	// ========================================
	// Test sequence
	// ========================================

	initial begin : main
		int s;
		int t;
		int w;
		logic [3:0] sel;
		logic [31:0] dat;
		logic [31:0] rdat;
		// Node index and word of every unicast write for the read-back pass
		int wr_node [N_UNI];
		int wr_word [N_UNI];
		void'($urandom(32'h9b0f_7a8d));
		rst = 1'b1;
		in_reset = 1'b1;
		cpu_req = '0;
		irq_in = '0;
		cause_in = '0;
		server_in = '0;
		for (int n = 0; n < NODES; n++) begin
			for (int k = 0; k < WORDS; k++) model[n][k] = '0;
		end
		test_start = 0;
		repeat (4) @(posedge clk);
		#1 rst = 1'b0;
		repeat (2) @(posedge clk);
		#1 in_reset = 1'b0;

		// Every word of every node is zero out of reset
		s = $urandom_range(0, NODES - 1);
		for (int n = 0; n < NODES; n++) begin
			for (int k = 0; k < WORDS; k++) read_check(s, node_adr(n, k), 32'h0);
		end
		end_test("reset state");

		for (int k = 0; k < N_UNI; k++) begin
			s = $urandom_range(0, NODES - 1);
			t = $urandom_range(0, NODES - 1);
			w = $urandom_range(0, WORDS - 1);
			sel = rand_sel();
			dat = $urandom;
			wr_node[k] = t;
			wr_word[k] = w;
			model[t][w] = merge(model[t][w], dat, sel);
			bus_op(s, 1'b1, sel, node_adr(t, w), dat, rdat);
			drain_ring();
		end
		// Each written word is read back from a random node
		for (int k = 0; k < N_UNI; k++) begin
			t = wr_node[k];
			w = wr_word[k];
			read_check($urandom_range(0, NODES - 1), node_adr(t, w), model[t][w]);
		end
		end_test("unicast write and read-back");

		// Reads from the originator follow the broadcast round the ring
		for (int r = 0; r < N_BC; r++) begin
			s = $urandom_range(0, NODES - 1);
			w = $urandom_range(0, WORDS - 1);
			sel = rand_sel();
			dat = $urandom;
			for (int n = 0; n < NODES; n++) model[n][w] = merge(model[n][w], dat, sel);
			bus_op(s, 1'b1, sel, bcast_adr(w), dat, rdat);
			for (int n = 0; n < NODES; n++) read_check(s, node_adr(n, w), model[n][w]);
		end
		end_test("broadcast write");

		s = $urandom_range(0, NODES - 1);
		t = $urandom_range(0, NODES - 1);
		w = $urandom_range(0, WORDS - 1);
		read_check(s, 32'h0000_1000, 32'h0);
		read_check(s, bcast_adr(w), 32'h0);
		read_check(s, {`RING_REGION_NODE, 4'd0, 12'h000, 6'(w), 2'b00}, 32'h0);
		bus_op(s, 1'b1, 4'hF, {8'h40, 4'(t + 1), 12'h000, 6'(w), 2'b00}, 32'hDEAD_BEEF, rdat);
		read_check(s, node_adr(t, w), model[t][w]);
		bus_op(s, 1'b1, 4'hF, {`RING_REGION_NODE, 4'd9, 12'h000, 6'(w), 2'b00},
			32'hFACE_0FF5, rdat);
		read_check(s, node_adr(0, w), model[0][w]);
		end_test("unmapped access");

		for (int n = 0; n < NODES; n++) begin
			automatic int nn = n;
			fork
				node_traffic(nn);
			join_none
		end
		wait fork;
		drain_ring();
		for (int n = 0; n < NODES; n++) begin
			for (int k = 0; k < NODES*N_CONC; k++) begin
				read_check($urandom_range(0, NODES - 1), node_adr(n, k), model[n][k]);
			end
		end
		end_test("concurrent traffic");

		for (int k = 0; k < 6; k++) begin
			raise_irq($urandom_range(0, NODES - 1), $urandom_range(0, NODES - 1),
				8'(8'h10 + k));
			wait_irq_done();
		end
		// All nodes raise on the same cycle with distinct causes
		@(posedge clk);
		#1;
		for (int a = 0; a < NODES; a++) begin
			t = $urandom_range(0, NODES - 1);
			exp_irq.push_back({8'(t), 8'(8'h80 + a)});
			irq_in[a] = 1'b1;
			cause_in[a] = 8'(8'h80 + a);
			server_in[a] = 6'(t + 1);
		end
		@(posedge clk);
		#1 irq_in = '0;
		wait_irq_done();
		end_test("interrupt delivery");

		$display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
		if (tests_failed == 0 && errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

/* sim.f */
+incdir+common
common/ring_pkg.sv
src/node_mem.sv
nic/ring_nic.sv
src/ring_top.sv
sim/ring_tb.sv
